/* Makefile */
# Verilator build and run for the TMU front end testbench.

VERILATOR ?= verilator
TOP       ?= tmu_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell cat $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* dv/tmu_tb.sv */
//########################################
// TMU front end testbench: CSR checks and
// mesh runs against a clipping model.
//########################################
`timescale 1ns/100ps
`default_nettype none

module tmu_tb;

	import tmu_csr_pkg::*;
	import tmu_geom_pkg::*;

	localparam logic [CSR_BANK_W-1:0] DUT_BANK = 4'h2;
	localparam logic [CSR_BANK_W-1:0] OTHER_BANK = 4'h5;
	// Seven runs of at most 80 squares, plus CSR traffic and drains.
	localparam int MAX_CYCLES = 4000;

	logic         sys_clk;
	logic         sys_rst;
	logic [13:0]  csr_a;
	logic         csr_we;
	logic [31:0]  csr_di;
	logic [31:0]  csr_do;
	logic         irq;
	square_desc_t square;
	logic         square_valid;

	square_desc_t exp_q[$];
	square_desc_t front;
	logic         run_active;
	logic         irq_q;
	int           got_cnt;
	int           irq_cnt;
	int           run_cnt;
	int           cycle_cnt;
	integer       seed;

	tmu_top #(
		.csr_addr(DUT_BANK)
	) dut_i (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.csr_a(csr_a),
		.csr_we(csr_we),
		.csr_di(csr_di),
		.csr_do(csr_do),
		.irq(irq),
		.square(square),
		.square_valid(square_valid)
	);

	always #4 sys_clk = ~sys_clk; // 8 ns period.

	task automatic abort_run(input string line);
		$display("%s", line);
		$display("TESTS FAILED");
		$fatal(1);
	endtask

	task automatic csr_write(input logic [3:0] bank, input csr_reg_e r, input logic [31:0] d);
		@(posedge sys_clk);
		#1;
		csr_a = {bank, 5'd0, r};
		csr_we = 1'b1;
		csr_di = d;
		@(posedge sys_clk);
		#1;
		csr_we = 1'b0;
	endtask

	task automatic csr_read(input logic [3:0] bank, input csr_reg_e r, output logic [31:0] d);
		@(posedge sys_clk);
		#1;
		csr_a = {bank, 5'd0, r};
		csr_we = 1'b0;
		@(posedge sys_clk);
		#1;
		d = csr_do; // Registered read data.
	endtask

	task automatic check_reg(input logic [3:0] bank, input csr_reg_e r, input logic [31:0] exp);
		logic [31:0] d;
		csr_read(bank, r, d);
		assert (d == exp)
			else abort_run($sformatf("Fail at %0t: bank %0d reg %0d read %h, expected %h",
				$time, bank, r, d, exp));
	endtask

	task automatic apply_config(input tmu_cfg_t c);
		csr_write(DUT_BANK, HLAST, 32'(c.vertex_hlast));
		csr_write(DUT_BANK, VLAST, 32'(c.vertex_vlast));
		csr_write(DUT_BANK, HRES, 32'(c.dst_hres));
		csr_write(DUT_BANK, VRES, 32'(c.dst_vres));
		csr_write(DUT_BANK, HOFFSET, 32'(c.dst_hoffset));
		csr_write(DUT_BANK, VOFFSET, 32'(c.dst_voffset));
		csr_write(DUT_BANK, SQUAREW, 32'(c.dst_squarew));
		csr_write(DUT_BANK, SQUAREH, 32'(c.dst_squareh));
	endtask

	// Row-major walk, each square clipped to [0, res).
	task automatic build_expected(input tmu_cfg_t c);
		int           hl, vl, sw, sh, hres, vres, hoff, voff;
		int           lft, top, x0, x1, y0, y1;
		square_desc_t e;
		hl = int'(c.vertex_hlast);
		vl = int'(c.vertex_vlast);
		sw = int'(c.dst_squarew);
		sh = int'(c.dst_squareh);
		hres = int'(c.dst_hres);
		vres = int'(c.dst_vres);
		hoff = int'($signed(c.dst_hoffset));
		voff = int'($signed(c.dst_voffset));
		exp_q.delete();
		for (int y = 0; y < vl; y++) begin
			for (int x = 0; x < hl; x++) begin
				lft = hoff + x * sw;
				top = voff + y * sh;
				x0 = (lft > 0) ? lft : 0;
				y0 = (top > 0) ? top : 0;
				x1 = (lft + sw < hres) ? lft + sw : hres;
				y1 = (top + sh < vres) ? top + sh : vres;
				if (x1 > x0 && y1 > y0) begin
					e.x = 11'(x0);
					e.y = 11'(y0);
					e.w = 11'(x1 - x0);
					e.h = 11'(y1 - y0);
					exp_q.push_back(e);
				end
			end
		end
	endtask

	task automatic run_mesh(input tmu_cfg_t c, input bit restart);
		logic [31:0] d;
		apply_config(c);
		build_expected(c);
		got_cnt = 0;
		run_active = 1'b1;
		run_cnt++;
		csr_write(DUT_BANK, CTRL, 32'd1);
		check_reg(DUT_BANK, CTRL, 32'd1); // Busy while running.
		if (restart) begin
			csr_write(DUT_BANK, CTRL, 32'd1); // Must be ignored.
		end
		d = 32'd1;
		while (d[0]) begin
			csr_read(DUT_BANK, CTRL, d);
		end
		assert (exp_q.size() == 0)
			else abort_run($sformatf("Fail at %0t: busy fell with %0d descriptors missing",
				$time, exp_q.size()));
		while (run_active) begin
			@(posedge sys_clk);
		end
		repeat (6) @(posedge sys_clk); // Nothing may follow the irq.
	endtask

	// Output monitor, sampled mid-cycle.
	always @(negedge sys_clk) begin
		if (!sys_rst) begin
			if (square_valid) begin
				assert (run_active && dut_i.busy)
					else abort_run($sformatf("Fail at %0t: descriptor outside a busy run",
						$time));
				assert (exp_q.size() != 0)
					else abort_run($sformatf("Fail at %0t: unexpected descriptor", $time));
				if (exp_q.size() != 0) begin
					front = exp_q.pop_front();
					assert (square == front)
						else abort_run($sformatf(
							"Fail at %0t: got %0d,%0d %0dx%0d, expected %0d,%0d %0dx%0d",
							$time, square.x, square.y, square.w, square.h,
							front.x, front.y, front.w, front.h));
					got_cnt++;
				end
			end
			if (irq) begin
				assert (!irq_q)
					else abort_run($sformatf("Fail at %0t: irq longer than one cycle", $time));
				assert (run_active)
					else abort_run($sformatf("Fail at %0t: irq with no run active", $time));
				irq_cnt++;
				run_active = 1'b0;
			end
			irq_q = irq;
		end
	end

	always @(posedge sys_clk) begin
		cycle_cnt++;
		if (cycle_cnt >= MAX_CYCLES) begin
			abort_run($sformatf("Timeout: the test did not end within %0d cycles", cycle_cnt));
		end
	end

	initial begin
		tmu_cfg_t c;
		seed = 32'h8e3d_fd28;
		sys_clk = 1'b0;
		sys_rst = 1'b1;
		csr_a = '0;
		csr_we = 1'b0;
		csr_di = '0;
		run_active = 1'b0;
		irq_q = 1'b0;
		got_cnt = 0;
		irq_cnt = 0;
		run_cnt = 0;
		cycle_cnt = 0;
		repeat (8) @(posedge sys_clk);
		#1;
		sys_rst = 1'b0;

		// Reset values.
		assert (irq == 1'b0)
			else abort_run($sformatf("Fail at %0t: irq high after reset", $time));
		check_reg(DUT_BANK, CTRL, 32'd0);
		check_reg(DUT_BANK, HLAST, 32'd32);
		check_reg(DUT_BANK, VLAST, 32'd24);
		check_reg(DUT_BANK, HRES, 32'd640);
		check_reg(DUT_BANK, VRES, 32'd480);
		check_reg(DUT_BANK, HOFFSET, 32'd0);
		check_reg(DUT_BANK, VOFFSET, 32'd0);
		check_reg(DUT_BANK, SQUAREW, 32'd20);
		check_reg(DUT_BANK, SQUAREH, 32'd20);
		check_reg(DUT_BANK, csr_reg_e'(5'd15), 32'd0); // Unused offset.

		// Readback, sign extension and bank decode.
		csr_write(DUT_BANK, HLAST, 32'd5);
		csr_write(DUT_BANK, HOFFSET, 32'hffff_fff9);
		csr_write(DUT_BANK, VOFFSET, 32'h0000_0ed4); // Only 12 bits are kept.
		csr_write(DUT_BANK, SQUAREW, 32'd13);
		check_reg(DUT_BANK, HLAST, 32'd5);
		check_reg(DUT_BANK, HOFFSET, 32'hffff_fff9);
		check_reg(DUT_BANK, VOFFSET, 32'hffff_fed4);
		check_reg(DUT_BANK, SQUAREW, 32'd13);
		csr_write(OTHER_BANK, HLAST, 32'd77);
		csr_write(OTHER_BANK, CTRL, 32'd1);
		check_reg(OTHER_BANK, HLAST, 32'd0);
		check_reg(DUT_BANK, HLAST, 32'd5);
		check_reg(DUT_BANK, CTRL, 32'd0);

		// Whole mesh inside the frame, with a start during the run.
		c = '{vertex_hlast: 7'd8, vertex_vlast: 7'd6, dst_hres: 11'd640, dst_vres: 11'd480,
			dst_hoffset: 12'sd10, dst_voffset: 12'sd20, dst_squarew: 11'd16,
			dst_squareh: 11'd12};
		run_mesh(c, 1'b1);
		assert (got_cnt == 48)
			else abort_run($sformatf("Fail at %0t: %0d squares, expected 48", $time, got_cnt));

		// Mesh larger than the frame and shifted up and left.
		c = '{vertex_hlast: 7'd10, vertex_vlast: 7'd8, dst_hres: 11'd100, dst_vres: 11'd60,
			dst_hoffset: -12'sd25, dst_voffset: -12'sd15, dst_squarew: 11'd20,
			dst_squareh: 11'd12};
		run_mesh(c, 1'b0);
		assert (got_cnt > 0 && got_cnt < 80)
			else abort_run($sformatf("Fail at %0t: %0d squares after clipping", $time, got_cnt));

		c.vertex_hlast = 7'd0; // Empty grid.
		c.vertex_vlast = 7'd4;
		run_mesh(c, 1'b0);

		for (int i = 0; i < 4; i++) begin
			c.vertex_hlast = 7'(1 + $unsigned($random(seed)) % 6);
			c.vertex_vlast = 7'(1 + $unsigned($random(seed)) % 6);
			c.dst_hres = 11'd120;
			c.dst_vres = 11'd90;
			c.dst_hoffset = 12'(int'($unsigned($random(seed)) % 81) - 40);
			c.dst_voffset = 12'(int'($unsigned($random(seed)) % 81) - 40);
			c.dst_squarew = 11'(1 + $unsigned($random(seed)) % 30);
			c.dst_squareh = 11'(1 + $unsigned($random(seed)) % 30);
			run_mesh(c, 1'b0);
		end

		$display("TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* source/tmu_csr_pkg.sv */
//########################################
// TMU register map and configuration
// types shared by the CSR block.
//########################################
`default_nettype none

package tmu_csr_pkg;

	// Bank select is csr_a[13:10].
	localparam int CSR_BANK_W = 4;

	typedef enum logic [4:0] {
		CTRL    = 5'd0, // Start in bit 0, busy on read.
		HLAST   = 5'd1,
		VLAST   = 5'd2,
		HRES    = 5'd3,
		VRES    = 5'd4,
		HOFFSET = 5'd5,
		VOFFSET = 5'd6,
		SQUAREW = 5'd7,
		SQUAREH = 5'd8
	} csr_reg_e;

	typedef struct packed {
		logic [6:0]         vertex_hlast; // Squares per row.
		logic [6:0]         vertex_vlast; // Squares per column.
		logic [10:0]        dst_hres;
		logic [10:0]        dst_vres;
		logic signed [11:0] dst_hoffset;
		logic signed [11:0] dst_voffset;
		logic [10:0]        dst_squarew;
		logic [10:0]        dst_squareh;
	} tmu_cfg_t;

	// A 32 by 24 mesh of 20 pixel squares on a VGA frame.
	localparam tmu_cfg_t CFG_RESET = '{
		vertex_hlast: 7'd32,
		vertex_vlast: 7'd24,
		dst_hres:     11'd640,
		dst_vres:     11'd480,
		dst_hoffset:  12'sd0,
		dst_voffset:  12'sd0,
		dst_squarew:  11'd20,
		dst_squareh:  11'd20
	};

endpackage

`default_nettype wire

/* source/tmu_ctlif.sv */
//########################################
// TMU control interface: register file,
// start pulse and end-of-run interrupt.
//########################################
`timescale 1ns/100ps
`default_nettype none

module tmu_ctlif #(
	parameter logic [tmu_csr_pkg::CSR_BANK_W-1:0] csr_addr = '0
) (
	input  wire                      sys_clk,
	input  wire                      sys_rst,

	input  wire [13:0]               csr_a,
	input  wire                      csr_we,
	input  wire [31:0]               csr_di,
	output logic [31:0]              csr_do,

	output logic                     irq,

	output logic                     start,
	input  wire                      busy,

	output tmu_csr_pkg::tmu_cfg_t    cfg
);

	import tmu_csr_pkg::*;

	logic     busy_q;
	logic     csr_sel;
	csr_reg_e csr_reg;

	assign csr_sel = (csr_a[13:10] == csr_addr);
	assign csr_reg = csr_reg_e'(csr_a[4:0]);

	// Previous busy, for the falling edge.
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			busy_q <= 1'b0;
		end else begin
			busy_q <= busy;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			irq <= 1'b0;
		end else begin
			irq <= busy_q & ~busy; // One pulse as the run ends.
		end
	end

	// Register writes and the start strobe.
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			start <= 1'b0;
			cfg <= CFG_RESET;
		end else begin
			start <= 1'b0;
			if (csr_sel && csr_we) begin
				case (csr_reg)
					CTRL:    start <= csr_di[0];
					HLAST:   cfg.vertex_hlast <= csr_di[6:0];
					VLAST:   cfg.vertex_vlast <= csr_di[6:0];
					HRES:    cfg.dst_hres <= csr_di[10:0];
					VRES:    cfg.dst_vres <= csr_di[10:0];
					HOFFSET: cfg.dst_hoffset <= csr_di[11:0];
					VOFFSET: cfg.dst_voffset <= csr_di[11:0];
					SQUAREW: cfg.dst_squarew <= csr_di[10:0];
					SQUAREH: cfg.dst_squareh <= csr_di[10:0];
					default: ;
				endcase
			end
		end
	end

	// Read data, one cycle after the address.
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			csr_do <= '0;
		end else if (!csr_sel) begin
			csr_do <= '0; // Other bank.
		end else begin
			case (csr_reg)
				CTRL:    csr_do <= {31'd0, busy};
				HLAST:   csr_do <= 32'(cfg.vertex_hlast);
				VLAST:   csr_do <= 32'(cfg.vertex_vlast);
				HRES:    csr_do <= 32'(cfg.dst_hres);
				VRES:    csr_do <= 32'(cfg.dst_vres);
				HOFFSET: csr_do <= 32'(cfg.dst_hoffset); // Sign-extended.
				VOFFSET: csr_do <= 32'(cfg.dst_voffset);
				SQUAREW: csr_do <= 32'(cfg.dst_squarew);
				SQUAREH: csr_do <= 32'(cfg.dst_squareh);
				default: csr_do <= '0;
			endcase
		end
	end

endmodule

`default_nettype wire

/* source/tmu_geom_pkg.sv */
//########################################
// TMU geometry types for the mesh walk
// and the square pipeline.
//########################################
`default_nettype none

package tmu_geom_pkg;

	// Signed destination coordinate width.
	localparam int COORD_W = 20;

	// Latency of the square generator.
	localparam int SQ_PIPE_DEPTH = 2;

	// Width of the sequencer drain counter.
	localparam int SQ_DRAIN_W = $clog2(SQ_PIPE_DEPTH + 1);

	typedef enum logic [1:0] {
		S_IDLE,
		S_RUN,
		S_DRAIN
	} seq_state_e;

	// Grid index of one square.
	typedef struct packed {
		logic [6:0] x;
		logic [6:0] y;
	} mesh_pos_t;

	// Clipped destination rectangle.
	typedef struct packed {
		logic [10:0] x;
		logic [10:0] y;
		logic [10:0] w;
		logic [10:0] h;
	} square_desc_t;

endpackage

`default_nettype wire

/* source/tmu_mesh_counter.sv */
//########################################
// Row-major counter over the mesh squares.
//########################################
`timescale 1ns/100ps
`default_nettype none

module tmu_mesh_counter (
	input  wire                       sys_clk,
	input  wire                       sys_rst,
	input  wire tmu_csr_pkg::tmu_cfg_t cfg,
	input  wire                       clear,
	input  wire                       step,
	output tmu_geom_pkg::mesh_pos_t   pos,
	output logic                      pos_valid,
	output logic                      last
);

	import tmu_geom_pkg::*;

	mesh_pos_t cur;
	logic      empty;
	logic      x_end;
	logic      y_end;

	assign empty = (cfg.vertex_hlast == '0) || (cfg.vertex_vlast == '0);
	assign x_end = (cur.x == cfg.vertex_hlast - 7'd1);
	assign y_end = (cur.y == cfg.vertex_vlast - 7'd1);

	assign pos = cur;
	assign pos_valid = step && !empty;
	assign last = empty || (x_end && y_end); // Final square, or nothing to do.

	always_ff @(posedge sys_clk) begin
		if (sys_rst || clear) begin
			cur <= '0;
		end else if (step && !empty) begin
			if (x_end) begin
				cur.x <= '0;
				cur.y <= cur.y + 7'd1; // Next row.
			end else begin
				cur.x <= cur.x + 7'd1;
			end
		end
	end

endmodule

`default_nettype wire

/* source/tmu_seq.sv */
//########################################
// TMU sequencer: runs the mesh walk and
// waits for the square pipeline to empty.
//########################################
`timescale 1ns/100ps
`default_nettype none

module tmu_seq (
	input  wire  sys_clk,
	input  wire  sys_rst,
	input  wire  start,
	input  wire  last,
	output logic busy,
	output logic step,
	output logic clear
);

	import tmu_geom_pkg::*;

	seq_state_e            state;
	logic [SQ_DRAIN_W-1:0] drain_cnt;

	assign busy = (state != S_IDLE);
	assign step = (state == S_RUN);
	assign clear = (state == S_IDLE) && start; // Rewinds the mesh counter.

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state <= S_IDLE;
			drain_cnt <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					if (start) begin
						state <= S_RUN;
					end
				end
				S_RUN: begin
					if (last) begin
						state <= S_DRAIN;
						drain_cnt <= SQ_DRAIN_W'(SQ_PIPE_DEPTH - 1);
					end
				end
				S_DRAIN: begin
					if (drain_cnt == '0) begin
						state <= S_IDLE;
					end else begin
						drain_cnt <= drain_cnt - 1'b1;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* source/tmu_square_gen.sv */
//########################################
// Square generator: places each square
// and clips it to the destination frame.
//########################################
`timescale 1ns/100ps
`default_nettype none

module tmu_square_gen (
	input  wire                        sys_clk,
	input  wire                        sys_rst,
	input  wire tmu_csr_pkg::tmu_cfg_t  cfg,
	input  wire tmu_geom_pkg::mesh_pos_t pos,
	input  wire                        pos_valid,
	output tmu_geom_pkg::square_desc_t square,
	output logic                       square_valid
);

	import tmu_geom_pkg::*;

	typedef struct packed {
		logic signed [COORD_W-1:0] lo;
		logic signed [COORD_W-1:0] len;
	} span_t;

	// Clip [lo_edge, lo_edge + size) against [0, limit).
	function automatic span_t clip_span(input logic signed [COORD_W-1:0] lo_edge,
			input logic [10:0] size, input logic [10:0] limit);
		logic signed [COORD_W-1:0] hi_edge;
		logic signed [COORD_W-1:0] lim;
		span_t s;
		hi_edge = lo_edge + COORD_W'(size);
		lim = COORD_W'(limit);
		s.lo = lo_edge[COORD_W-1] ? '0 : lo_edge;
		s.len = ((hi_edge < lim) ? hi_edge : lim) - s.lo;
		return s;
	endfunction

	logic signed [COORD_W-1:0] left_c, top_c;
	logic signed [COORD_W-1:0] s1_left, s1_top;
	logic                      s1_valid;
	span_t                     h_span, v_span;
	logic                      visible;

	// Stage 1: offset plus grid index times square size.
	assign left_c = COORD_W'(cfg.dst_hoffset) + COORD_W'(pos.x * cfg.dst_squarew);
	assign top_c = COORD_W'(cfg.dst_voffset) + COORD_W'(pos.y * cfg.dst_squareh);

	always_ff @(posedge sys_clk) begin
		s1_left <= left_c;
		s1_top <= top_c;
		if (sys_rst) begin
			s1_valid <= 1'b0;
		end else begin
			s1_valid <= pos_valid;
		end
	end

	// Stage 2: clip both axes, drop empty results.
	assign h_span = clip_span(s1_left, cfg.dst_squarew, cfg.dst_hres);
	assign v_span = clip_span(s1_top, cfg.dst_squareh, cfg.dst_vres);
	assign visible = !h_span.len[COORD_W-1] && (h_span.len != '0)
		&& !v_span.len[COORD_W-1] && (v_span.len != '0);

	always_ff @(posedge sys_clk) begin
		square.x <= h_span.lo[10:0];
		square.y <= v_span.lo[10:0];
		square.w <= h_span.len[10:0];
		square.h <= v_span.len[10:0];
		if (sys_rst) begin
			square_valid <= 1'b0;
		end else begin
			square_valid <= s1_valid && visible;
		end
	end

endmodule

`default_nettype wire

/* source/tmu_top.sv */
//########################################
// TMU front end: CSRs, sequencer, mesh
// counter and square generator.
//########################################
`timescale 1ns/100ps
`default_nettype none

module tmu_top #(
	parameter logic [tmu_csr_pkg::CSR_BANK_W-1:0] csr_addr = '0
) (
	input  wire                        sys_clk,
	input  wire                        sys_rst,
	input  wire [13:0]                 csr_a,
	input  wire                        csr_we,
	input  wire [31:0]                 csr_di,
	output logic [31:0]                csr_do,
	output logic                       irq,
	output tmu_geom_pkg::square_desc_t square,
	output logic                       square_valid
);

	import tmu_csr_pkg::*;
	import tmu_geom_pkg::*;

	tmu_cfg_t  cfg;
	mesh_pos_t pos;
	logic      start, busy;
	logic      step, clear;
	logic      pos_valid, last;

	tmu_ctlif #(
		.csr_addr(csr_addr)
	) u_ctlif (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.csr_a(csr_a),
		.csr_we(csr_we),
		.csr_di(csr_di),
		.csr_do(csr_do),
		.irq(irq),
		.start(start),
		.busy(busy),
		.cfg(cfg)
	);

	tmu_seq u_seq (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.start(start),
		.last(last),
		.busy(busy),
		.step(step),
		.clear(clear)
	);

	tmu_mesh_counter u_mesh (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.cfg(cfg),
		.clear(clear),
		.step(step),
		.pos(pos),
		.pos_valid(pos_valid),
		.last(last)
	);

	tmu_square_gen u_square (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.cfg(cfg),
		.pos(pos),
		.pos_valid(pos_valid),
		.square(square),
		.square_valid(square_valid)
	);

endmodule

`default_nettype wire

/* verilog.f */
source/tmu_csr_pkg.sv
source/tmu_geom_pkg.sv
source/tmu_ctlif.sv
source/tmu_seq.sv
source/tmu_mesh_counter.sv
source/tmu_square_gen.sv
source/tmu_top.sv
dv/tmu_tb.sv
